/* rtl/conv_data_pkg.sv */
package conv_data_pkg;

	// datapath sizes
	localparam int DATA_WIDTH     = 16;
	localparam int ACC_WIDTH      = 32;
	localparam int KERNEL_SIZE    = 9;
	localparam int KERNEL_SLOTS   = 2;
	localparam int TAP_CNT_WIDTH  = 4;
	localparam int SLOT_PTR_WIDTH = $clog2(KERNEL_SLOTS);

	// one weight or one pixel
	typedef logic signed [DATA_WIDTH-1:0] data_t;

	// products and running sums wrapping modulo 2**32
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	typedef logic [TAP_CNT_WIDTH-1:0] tap_cnt_t;

	// nine taps packed with tap 0 in the low bits
	typedef logic [KERNEL_SIZE*DATA_WIDTH-1:0] kernel_vec_t;

	// kernel queue pointer and fill level
	typedef logic [SLOT_PTR_WIDTH-1:0] slot_ptr_t;
	typedef logic [SLOT_PTR_WIDTH:0]   slot_cnt_t;

endpackage

/* rtl/conv_bus_pkg.sv */
package conv_bus_pkg;

	localparam int APB_ADDR_WIDTH = 8;
	localparam int APB_DATA_WIDTH = 32;

	typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
	typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

	// register map
	localparam apb_addr_t ADDR_WEIGHT = 8'h00;
	localparam apb_addr_t ADDR_PIXEL  = 8'h04;
	localparam apb_addr_t ADDR_CTRL   = 8'h08;
	localparam apb_addr_t ADDR_STATUS = 8'h0C;
	localparam apb_addr_t ADDR_RESULT = 8'h10;

	// ctrl register bit that requests a kernel load
	localparam int CTRL_LOAD = 0;

	// status word bit positions
	localparam int STAT_KERNEL_ACTIVE = 0;
	localparam int STAT_RESULT_VALID  = 1;
	localparam int STAT_MAC_BUSY      = 2;
	localparam int STAT_QUEUE_COUNT   = 4;

	typedef enum logic [1:0] {IDLE, ACCESS, WAIT} apb_state_t;
	typedef enum logic [1:0] {COLLECT, ACCUMULATE, DONE} mac_state_t;

endpackage

/* rtl/apb_conv_port.sv */
module apb_conv_port (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  conv_bus_pkg::apb_addr_t  paddr,
	input  conv_bus_pkg::apb_data_t  pwdata,
	output logic                     pready,
	output conv_bus_pkg::apb_data_t  prdata,
	output logic                     pslverr,
	output logic                     weight_valid,
	output conv_data_pkg::data_t     weight_data,
	input  logic                     weight_ready,
	output logic                     load_kernel,
	output logic                     pixel_valid,
	output conv_data_pkg::data_t     pixel_data,
	input  logic                     pixel_ready,
	output logic                     result_read,
	input  logic                     kernel_active,
	input  conv_data_pkg::slot_cnt_t queue_count,
	input  logic                     mac_busy,
	input  logic                     result_valid,
	input  conv_data_pkg::acc_t      result
);
	import conv_data_pkg::*;
	import conv_bus_pkg::*;

	apb_state_t state;
	apb_state_t state_next;

	logic      hit_weight;
	logic      hit_pixel;
	logic      hit_ctrl;
	logic      hit_status;
	logic      hit_result;
	logic      bad_access;
	logic      stream_write;
	logic      stream_ready;
	logic      access;
	apb_data_t status_word;
	apb_data_t read_word;

	////////////////////
	// address decode
	assign hit_weight = (paddr == ADDR_WEIGHT);
	assign hit_pixel  = (paddr == ADDR_PIXEL);
	assign hit_ctrl   = (paddr == ADDR_CTRL);
	assign hit_status = (paddr == ADDR_STATUS);
	assign hit_result = (paddr == ADDR_RESULT);

	// unmapped, or a write to one of the read-only offsets
	assign bad_access = !(hit_weight || hit_pixel || hit_ctrl || hit_status || hit_result)
		|| (pwrite && (hit_status || hit_result));

	// weight and pixel writes are the only ones that can stall
	assign stream_write = pwrite && (hit_weight || hit_pixel);
	assign stream_ready = hit_weight ? weight_ready : pixel_ready;
	assign access       = (state == ACCESS) && psel && penable;

	////////////////////
	// transfer FSM
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (psel && !penable) begin
					state_next = ACCESS;
				end
			end
			ACCESS: begin
				if (psel && stream_write) begin
					state_next = WAIT;
				end else begin
					state_next = IDLE;
				end
			end
			WAIT: begin
				if (!psel || stream_ready) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	assign pready  = (access && !stream_write) || ((state == WAIT) && stream_ready);
	assign pslverr = access && bad_access;

	////////////////////
	// strobes toward buffer and MAC
	assign weight_valid = (state == WAIT) && hit_weight;
	assign pixel_valid  = (state == WAIT) && hit_pixel;
	assign weight_data  = pwdata[DATA_WIDTH-1:0];
	assign pixel_data   = pwdata[DATA_WIDTH-1:0];
	assign load_kernel  = access && pwrite && hit_ctrl && pwdata[CTRL_LOAD];
	assign result_read  = access && !pwrite && hit_result;

	// status word assembly
	always_comb begin
		status_word = '0;
		status_word[STAT_KERNEL_ACTIVE] = kernel_active;
		status_word[STAT_RESULT_VALID] = result_valid;
		status_word[STAT_MAC_BUSY] = mac_busy;
		status_word[STAT_QUEUE_COUNT +: $bits(slot_cnt_t)] = queue_count;
	end

	assign read_word = hit_status ? status_word :
		hit_result ? apb_data_t'(result) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= IDLE;
			prdata <= '0;
		end else begin
			state <= state_next;
			// sampled during setup so reads need no wait state
			if ((state == IDLE) && psel && !penable && !pwrite) begin
				prdata <= read_word;
			end
		end
	end

endmodule

/* rtl/kernel_weight_buffer.sv */
module kernel_weight_buffer (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       weight_valid,
	input  conv_data_pkg::data_t       weight_data,
	output logic                       weight_ready,
	input  logic                       load_kernel,
	output conv_data_pkg::kernel_vec_t active_weights,
	output logic                       kernel_active,
	output conv_data_pkg::slot_cnt_t   queue_count
);
	import conv_data_pkg::*;

	// gathering chain
	data_t       chain [KERNEL_SIZE];
	kernel_vec_t chain_flat;
	tap_cnt_t    tap_cnt;
	logic        chain_full;
	logic        accept;

	// kernel queue
	kernel_vec_t slots [KERNEL_SLOTS];
	slot_ptr_t   wr_ptr;
	slot_ptr_t   rd_ptr;
	logic        queue_full;
	logic        queue_empty;
	logic        commit;
	logic        pop;

	function automatic slot_ptr_t next_ptr(input slot_ptr_t ptr);
		if (ptr == slot_ptr_t'(KERNEL_SLOTS - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign chain_full   = (tap_cnt == tap_cnt_t'(KERNEL_SIZE));
	assign weight_ready = !chain_full;
	assign accept       = weight_valid && weight_ready;

	assign queue_full  = (queue_count == slot_cnt_t'(KERNEL_SLOTS));
	assign queue_empty = (queue_count == '0);

	// a full chain waits here until a slot frees up
	assign commit = chain_full && !queue_full;
	assign pop    = load_kernel && !queue_empty;

	////////////////////
	// shift chain
	// newest word enters the top stage, first word ends up as tap 0
	always_ff @(posedge clk) begin
		if (accept) begin
			chain[KERNEL_SIZE-1] <= weight_data;
			for (int i = 0; i < KERNEL_SIZE - 1; i++) begin
				chain[i] <= chain[i+1];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < KERNEL_SIZE; i++) begin
			chain_flat[i*DATA_WIDTH +: DATA_WIDTH] = chain[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tap_cnt <= '0;
		end else if (commit) begin
			tap_cnt <= '0;
		end else if (accept) begin
			tap_cnt <= tap_cnt + 1'b1;
		end
	end

	////////////////////
	// kernel queue
	always_ff @(posedge clk) begin
		if (commit) begin
			slots[wr_ptr] <= chain_flat;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			queue_count <= '0;
		end else begin
			if (commit) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({commit, pop})
				2'b10: queue_count <= queue_count + 1'b1;
				2'b01: queue_count <= queue_count - 1'b1;
				default: queue_count <= queue_count;
			endcase
		end
	end

	// active kernel seen by the MAC
	always_ff @(posedge clk) begin
		if (pop) begin
			active_weights <= slots[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			kernel_active <= 1'b0;
		end else if (pop) begin
			kernel_active <= 1'b1;
		end
	end

endmodule

/* rtl/window_mac.sv */
module window_mac (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       pixel_valid,
	input  conv_data_pkg::data_t       pixel_data,
	output logic                       pixel_ready,
	input  logic                       kernel_active,
	input  conv_data_pkg::kernel_vec_t active_weights,
	input  logic                       result_read,
	output logic                       mac_busy,
	output logic                       result_valid,
	output conv_data_pkg::acc_t        result
);
	import conv_data_pkg::*;
	import conv_bus_pkg::*;

	mac_state_t state;
	data_t      window [KERNEL_SIZE];
	tap_cnt_t   tap_cnt;
	logic       window_full;
	logic       last_tap;
	logic       accept;
	data_t      tap_weight;
	data_t      tap_pixel;
	acc_t       product;
	acc_t       acc;
	acc_t       acc_sum;

	// tap_cnt counts pixels in COLLECT and steps in ACCUMULATE
	assign window_full = (state == COLLECT) && (tap_cnt == tap_cnt_t'(KERNEL_SIZE));
	assign last_tap    = (tap_cnt == tap_cnt_t'(KERNEL_SIZE - 1));

	assign pixel_ready  = kernel_active && (state != ACCUMULATE) && !window_full;
	assign accept       = pixel_valid && pixel_ready;
	assign mac_busy     = (state == ACCUMULATE) || window_full;
	assign result_valid = (state == DONE);

	////////////////////
	// pixel window
	always_ff @(posedge clk) begin
		if (accept) begin
			window[KERNEL_SIZE-1] <= pixel_data;
			for (int i = 0; i < KERNEL_SIZE - 1; i++) begin
				window[i] <= window[i+1];
			end
		end
	end

	////////////////////
	// single multiplier, one tap per cycle
	assign tap_weight = active_weights[tap_cnt*DATA_WIDTH +: DATA_WIDTH];
	assign tap_pixel  = window[tap_cnt];
	assign product    = tap_weight * tap_pixel;
	assign acc_sum    = acc + product;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= COLLECT;
			tap_cnt <= '0;
		end else begin
			case (state)
				COLLECT: begin
					if (window_full) begin
						state   <= ACCUMULATE;
						tap_cnt <= '0;
					end else if (accept) begin
						tap_cnt <= tap_cnt + 1'b1;
					end
				end
				ACCUMULATE: begin
					if (last_tap) begin
						state   <= DONE;
						tap_cnt <= '0;
					end else begin
						tap_cnt <= tap_cnt + 1'b1;
					end
				end
				DONE: begin
					// first pixel of a new window also drops the old result
					if (accept) begin
						state   <= COLLECT;
						tap_cnt <= tap_cnt_t'(1);
					end else if (result_read) begin
						state <= COLLECT;
					end
				end
				default: state <= COLLECT;
			endcase
		end
	end

	// accumulator cleared on the way into ACCUMULATE
	always_ff @(posedge clk) begin
		if (window_full) begin
			acc <= '0;
		end else if (state == ACCUMULATE) begin
			acc <= acc_sum;
		end
		if ((state == ACCUMULATE) && last_tap) begin
			result <= acc_sum;
		end
	end

endmodule

/* rtl/conv3x3_top.sv */
module conv3x3_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  conv_bus_pkg::apb_addr_t paddr,
	input  conv_bus_pkg::apb_data_t pwdata,
	output logic                    pready,
	output conv_bus_pkg::apb_data_t prdata,
	output logic                    pslverr
);
	import conv_data_pkg::*;

	// port to buffer
	logic        weight_valid;
	data_t       weight_data;
	logic        weight_ready;
	logic        load_kernel;
	slot_cnt_t   queue_count;
	kernel_vec_t active_weights;
	logic        kernel_active;

	// port to MAC
	logic        pixel_valid;
	data_t       pixel_data;
	logic        pixel_ready;
	logic        result_read;
	logic        mac_busy;
	logic        result_valid;
	acc_t        result;

	apb_conv_port u_port (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.pready(pready), .prdata(prdata), .pslverr(pslverr),
		.weight_valid(weight_valid), .weight_data(weight_data),
		.weight_ready(weight_ready), .load_kernel(load_kernel),
		.pixel_valid(pixel_valid), .pixel_data(pixel_data), .pixel_ready(pixel_ready),
		.result_read(result_read), .kernel_active(kernel_active),
		.queue_count(queue_count), .mac_busy(mac_busy),
		.result_valid(result_valid), .result(result)
	);

	kernel_weight_buffer u_buffer (
		.clk(clk), .reset(reset),
		.weight_valid(weight_valid), .weight_data(weight_data),
		.weight_ready(weight_ready), .load_kernel(load_kernel),
		.active_weights(active_weights), .kernel_active(kernel_active),
		.queue_count(queue_count)
	);

	window_mac u_mac (
		.clk(clk), .reset(reset),
		.pixel_valid(pixel_valid), .pixel_data(pixel_data), .pixel_ready(pixel_ready),
		.kernel_active(kernel_active), .active_weights(active_weights),
		.result_read(result_read), .mac_busy(mac_busy),
		.result_valid(result_valid), .result(result)
	);

endmodule

/* verification/conv3x3_tb.sv */
module conv3x3_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int XFER_LIMIT = 16;

	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic        pready;
	logic [31:0] prdata;
	logic        pslverr;

	// outcome of the most recent transfer
	logic [31:0] last_rdata;
	logic        last_err;

	conv3x3_top DUT (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.pready(pready), .prdata(prdata), .pslverr(pslverr)
	);

	always #20 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		assert (exp === got) else begin
			$display("error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	////////////////////
	// APB master
	// outputs change on the rising edge, pready is sampled on the falling edge
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
			input int limit, output logic done);
		int cycles;
		repeat (1 + $urandom % 4) @(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!pready && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		done = pready;
		last_rdata = prdata;
		last_err = pslverr;
		// a timed out transfer is dropped here as well
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
		logic done;
		apb_xfer(wr, addr, data, XFER_LIMIT, done);
		if (!done) begin
			fail_run($sformatf("transfer to address %h did not complete", addr));
		end
	endtask

	task automatic poll_status(input int bit_pos, input int limit);
		int polls;
		polls = 0;
		do begin
			transfer(1'b0, 8'h0C, '0);
			polls++;
		end while (!last_rdata[bit_pos] && polls < limit);
		if (!last_rdata[bit_pos]) begin
			fail_run($sformatf("status bit %0d not set after %0d reads", bit_pos, limit));
		end
	endtask

	// kernel load strobe raised beside the bus while a weight write stalls
	task automatic side_load(input int delay);
		int stalled;
		int waited;
		stalled = 0;
		waited = 0;
		while (stalled <= delay && waited < XFER_LIMIT + delay) begin
			@(negedge clk);
			waited++;
			if (psel && penable) begin
				assert (!pready) else fail_run("stalled weight write finished before the load");
				stalled++;
			end
		end
		if (stalled <= delay) begin
			fail_run("weight write never reached its access phase");
		end
		force DUT.load_kernel = 1'b1;
		@(negedge clk);
		release DUT.load_kernel;
	endtask

	initial begin
		int          fd;
		int          n;
		int          lim;
		int          load_delay;
		string       line;
		byte         c;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] v [9];
		logic        done;
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		void'($urandom(30));
		fd = $fopen("verification/conv3x3_input.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open verification/conv3x3_input.txt");
		end
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			c = line[0];
			n = $sscanf(line, "%c %h %h %d", c, a, d, lim);
			case (c)
				"W": begin
					transfer(1'b1, a[7:0], d);
					check_value("pslverr", lim, {31'b0, last_err});
				end
				"R": begin
					transfer(1'b0, a[7:0], '0);
					check_value($sformatf("prdata @%h", a[7:0]), d, last_rdata);
					check_value("pslverr", lim, {31'b0, last_err});
				end
				"K": begin
					n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", c, a,
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
					for (int i = 0; i < 9; i++) begin
						transfer(1'b1, a[7:0], v[i]);
						check_value("pslverr", 32'h0, {31'b0, last_err});
					end
				end
				"S": begin
					n = $sscanf(line, "%c %d %d", c, a, d);
					poll_status(a, d);
				end
				"T": begin
					apb_xfer(1'b1, a[7:0], d, lim, done);
					assert (!done) else fail_run("pixel write was accepted with no kernel loaded");
					$display("write to %h not accepted within %0d cycles", a[7:0], lim);
				end
				"H": begin
					load_delay = 3 + $urandom % 4;
					fork
						apb_xfer(1'b1, a[7:0], d, lim, done);
						side_load(load_delay);
					join
					assert (done) else fail_run("stalled weight write did not complete after the load");
				end
				default: fail_run($sformatf("unknown command in line: %s", line));
			endcase
		end
		$fclose(fd);
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* verification/conv3x3_input.txt */
# W addr data err | R addr expected err | K addr nine words | S status_bit max_reads
# T addr data cycles (must stall) | H addr data cycles (released by a side load)
R 0C 00000000 0
T 04 00000001 20
K 00 0001 0002 0003 0004 0005 0006 0007 0008 0009
W 08 00000001 0
R 0C 00000001 0
K 04 0009 0008 0007 0006 0005 0004 0003 0002 0001
S 1 20
R 10 000000A5 0
R 0C 00000001 0
K 00 0002 0000 FFFF 0000 0003 0000 FFFE 0000 0001
K 00 0001 0001 0001 0001 0001 0001 0001 0001 0001
R 0C 00000021 0
K 00 8000 8000 8000 8000 8000 8000 8000 8000 7FFF
H 00 00000005 40
R 0C 00000021 0
K 04 000A 0014 001E 0028 0032 003C 0046 0050 005A
S 1 20
R 10 0000005A 0
W 08 00000001 0
K 04 000A 0014 001E 0028 0032 003C 0046 0050 005A
S 1 20
R 10 000001C2 0
W 08 00000001 0
K 04 8000 8000 8000 8000 8000 8000 8000 8000 8000
S 1 20
R 10 C0008000 0
W 20 00001234 1
R 24 00000000 1
W 10 0000DEAD 1
R 10 C0008000 0
R 0C 00000001 0

/* conv3x3.f */
rtl/conv_data_pkg.sv
rtl/conv_bus_pkg.sv
rtl/apb_conv_port.sv
rtl/kernel_weight_buffer.sv
rtl/window_mac.sv
rtl/conv3x3_top.sv
verification/conv3x3_tb.sv

/* Bender.yml */
package:
  name: conv3x3

sources:
  - files:
      - rtl/conv_data_pkg.sv
      - rtl/conv_bus_pkg.sv
      - rtl/apb_conv_port.sv
      - rtl/kernel_weight_buffer.sv
      - rtl/window_mac.sv
      - rtl/conv3x3_top.sv
  - target: test
    files:
      - verification/conv3x3_tb.sv
